//--- source/fpu_pkg.sv
// shared widths, encodings and operation codes for the single-precision FPU
// imported by every module of the design

package fpu_pkg;

  // IEEE single field widths
  localparam int word_w = 32;
  localparam int exp_w  = 8;
  localparam int frac_w = 23;
  // fraction plus hidden bit
  localparam int mant_w = 24;
  // mantissa plus carry bit plus sign guard bit
  localparam int addsub_w = 26;
  // leading-zero count of a 24 bit mantissa needs 0..24
  localparam int lz_w = 5;

  localparam int exp_bias = 127;

  // exponent used by infinity and NaN
  localparam logic [exp_w-1:0] exp_all_ones = 8'hFF;
  // quiet NaN returned for infinity times zero
  localparam logic [word_w-1:0] qnan_word = 32'h7FC0_0000;

  // operation codes, code 3 is unused and yields zero
  localparam int op_w = 2;
  localparam logic [op_w-1:0] op_add = 2'd0;
  localparam logic [op_w-1:0] op_sub = 2'd1;
  localparam logic [op_w-1:0] op_mul = 2'd2;

  // command FSM states
  localparam int st_w = 2;
  // waiting for start
  localparam logic [st_w-1:0] st_idle = 2'd0;
  // operands loaded, datapaths settling
  localparam logic [st_w-1:0] st_calc = 2'd1;
  // result registered
  localparam logic [st_w-1:0] st_done = 2'd2;
  // cmd_end raised, waiting for start to drop
  localparam logic [st_w-1:0] st_wait = 2'd3;

endpackage

//--- source/fpu_addsub.sv
// combinational add/subtract datapath for IEEE single words
// align exponents, add in two's complement, normalize and truncate

`timescale 1ns/100ps

module fpu_addsub (
  input  logic [fpu_pkg::word_w-1:0] opa,
  input  logic [fpu_pkg::word_w-1:0] opb,
  input  logic [fpu_pkg::op_w-1:0]   op_q,
  output logic [fpu_pkg::word_w-1:0] addsub_result
);
  import fpu_pkg::*;

  logic                sign_a;
  logic                sign_b;
  logic [exp_w-1:0]    exp_a;
  logic [exp_w-1:0]    exp_b;
  logic [exp_w-1:0]    exp_big;
  logic [addsub_w-1:0] mant_a;
  logic [addsub_w-1:0] mant_b;
  logic [addsub_w-1:0] aligned_a;
  logic [addsub_w-1:0] aligned_b;
  logic [addsub_w-1:0] signed_a;
  logic [addsub_w-1:0] signed_b;
  logic [addsub_w-1:0] sum;
  logic [addsub_w-1:0] sum_abs;
  logic                sum_sign;
  logic [lz_w-1:0]     lz_count;
  logic [mant_w-1:0]   norm_mant;
  logic [exp_w-1:0]    norm_exp;

  // number of zeros above the first set bit, mant_w when the value is zero
  function automatic logic [lz_w-1:0] lead_zeros(input logic [mant_w-1:0] value);
    logic [lz_w-1:0] count;
    logic            found;
    count = lz_w'(mant_w);
    found = 1'b0;
    for (int i = mant_w - 1; i >= 0; i--) begin
      if (value[i] && !found) begin
        count = lz_w'(mant_w - 1 - i);
        found = 1'b1;
      end
    end
    return count;
  endfunction

  // unpack, hidden bit only for nonzero exponent
  assign sign_a = opa[word_w-1];
  assign sign_b = opb[word_w-1];
  assign exp_a  = opa[word_w-2:frac_w];
  assign exp_b  = opb[word_w-2:frac_w];
  // two top bits left free for carry and sign
  assign mant_a = {2'b00, exp_a != '0, opa[frac_w-1:0]};
  assign mant_b = {2'b00, exp_b != '0, opb[frac_w-1:0]};

  // smaller operand moves right until both share the larger exponent
  assign exp_big   = (exp_a < exp_b) ? exp_b : exp_a;
  assign aligned_a = mant_a >> (exp_big - exp_a);
  assign aligned_b = mant_b >> (exp_big - exp_b);

  // signed magnitudes into two's complement
  assign signed_a = sign_a ? -aligned_a : aligned_a;
  assign signed_b = sign_b ? -aligned_b : aligned_b;

  assign sum      = (op_q == op_sub) ? signed_a - signed_b : signed_a + signed_b;
  assign sum_sign = sum[addsub_w-1];
  assign sum_abs  = sum_sign ? -sum : sum;
  assign lz_count = lead_zeros(sum_abs[mant_w-1:0]);

  always_comb begin
    if (sum_abs == '0) begin
      // exact cancellation gives positive zero
      norm_mant = '0;
      norm_exp  = '0;
    end else if (sum_abs[mant_w]) begin
      // carry out of the mantissa, drop one bit
      norm_mant = sum_abs[mant_w:1];
      norm_exp  = exp_big + 1'b1;
    end else begin
      // cancellation moves the leading one back to the hidden position
      norm_mant = sum_abs[mant_w-1:0] << lz_count;
      norm_exp  = exp_big - exp_w'(lz_count);
    end
  end

  assign addsub_result = {sum_sign, norm_exp, norm_mant[frac_w-1:0]};

endmodule

//--- source/fpu_mul.sv
// combinational multiply datapath for IEEE single words
// round to nearest even, with NaN, infinity and zero overrides

`timescale 1ns/100ps

module fpu_mul (
  input  logic [fpu_pkg::word_w-1:0] opa,
  input  logic [fpu_pkg::word_w-1:0] opb,
  output logic [fpu_pkg::word_w-1:0] mul_result
);
  import fpu_pkg::*;

  logic                  sign_a;
  logic                  sign_b;
  logic                  res_sign;
  logic [exp_w-1:0]      exp_a;
  logic [exp_w-1:0]      exp_b;
  logic [frac_w-1:0]     frac_a;
  logic [frac_w-1:0]     frac_b;
  logic [mant_w-1:0]     mant_a;
  logic [mant_w-1:0]     mant_b;
  logic [2*mant_w-1:0]   product;
  logic [2*mant_w-1:0]   prod_norm;
  logic [exp_w-1:0]      exp_sum;
  logic [exp_w-1:0]      exp_norm;
  logic                  rnd_guard;
  logic                  rnd_sticky;
  logic                  round_up;
  logic [mant_w:0]       rounded;
  logic [mant_w-1:0]     final_mant;
  logic [exp_w-1:0]      final_exp;
  logic                  a_nan;
  logic                  a_inf;
  logic                  a_zero;
  logic                  b_nan;
  logic                  b_inf;
  logic                  b_zero;

  assign sign_a = opa[word_w-1];
  assign sign_b = opb[word_w-1];
  assign exp_a  = opa[word_w-2:frac_w];
  assign exp_b  = opb[word_w-2:frac_w];
  assign frac_a = opa[frac_w-1:0];
  assign frac_b = opb[frac_w-1:0];
  assign mant_a = {exp_a != '0, frac_a};
  assign mant_b = {exp_b != '0, frac_b};

  assign res_sign = sign_a ^ sign_b;

  // operand classes
  assign a_nan  = (exp_a == exp_all_ones) && (frac_a != '0);
  assign a_inf  = (exp_a == exp_all_ones) && (frac_a == '0);
  assign a_zero = (exp_a == '0) && (frac_a == '0);
  assign b_nan  = (exp_b == exp_all_ones) && (frac_b != '0);
  assign b_inf  = (exp_b == exp_all_ones) && (frac_b == '0);
  assign b_zero = (exp_b == '0) && (frac_b == '0);

  // product of two 1.x values lies in [1, 4)
  assign product = mant_a * mant_b;
  // biased exponents add, one bias removed
  assign exp_sum = exp_a + exp_b - exp_w'(exp_bias);

  // top bit set means 1x.xxx, bump the exponent
  // otherwise shift so the leading one sits at the top
  assign exp_norm  = product[2*mant_w-1] ? exp_sum + 1'b1 : exp_sum;
  assign prod_norm = product[2*mant_w-1] ? product : product << 1;

  // keep the upper mant_w bits, guard is the next one, sticky the rest
  assign rnd_guard  = prod_norm[mant_w-1];
  assign rnd_sticky = |prod_norm[mant_w-2:0];
  // exact halfway only rounds up when the kept lsb is odd
  assign round_up   = rnd_guard && (rnd_sticky || prod_norm[mant_w]);
  assign rounded    = {1'b0, prod_norm[2*mant_w-1:mant_w]} + (mant_w+1)'(round_up);

  // rounding carry gives 10.000, renormalize
  assign final_mant = rounded[mant_w] ? rounded[mant_w:1] : rounded[mant_w-1:0];
  assign final_exp  = rounded[mant_w] ? exp_norm + 1'b1 : exp_norm;

  always_comb begin
    if (a_nan) begin
      mul_result = opa;
    end else if (b_nan) begin
      mul_result = opb;
    end else if ((a_inf && b_zero) || (a_zero && b_inf)) begin
      mul_result = qnan_word;
    end else if (a_inf || b_inf) begin
      mul_result = {res_sign, exp_all_ones, {frac_w{1'b0}}};
    end else if (a_zero || b_zero) begin
      mul_result = {res_sign, {(word_w-1){1'b0}}};
    end else begin
      // no overflow or underflow saturation
      mul_result = {res_sign, final_exp, final_mant[frac_w-1:0]};
    end
  end

endmodule

//--- source/fpu_control.sv
// command controller of the FPU
// runs the start/busy/cmd_end handshake, holds operands and registers the result

`timescale 1ns/100ps

module fpu_control (
  input  logic                       clk,
  input  logic                       arst,
  input  logic [fpu_pkg::word_w-1:0] a,
  input  logic [fpu_pkg::word_w-1:0] b,
  input  logic [fpu_pkg::op_w-1:0]   op,
  input  logic                       start,
  input  logic [fpu_pkg::word_w-1:0] addsub_result,
  input  logic [fpu_pkg::word_w-1:0] mul_result,
  output logic [fpu_pkg::word_w-1:0] opa,
  output logic [fpu_pkg::word_w-1:0] opb,
  output logic [fpu_pkg::op_w-1:0]   op_q,
  output logic [fpu_pkg::word_w-1:0] result,
  output logic                       busy,
  output logic                       cmd_end
);
  import fpu_pkg::*;

  logic [st_w-1:0]   state;
  logic [st_w-1:0]   next_state;
  logic [word_w-1:0] sel_result;

  // next state
  always_comb begin
    next_state = state;
    case (state)
      st_idle: begin
        if (start) begin
          next_state = st_calc;
        end
      end
      // datapaths settle on the loaded operands for one cycle
      st_calc: next_state = st_done;
      st_done: next_state = st_wait;
      // hold here until start drops
      st_wait: begin
        if (!start) begin
          next_state = st_idle;
        end
      end
      default: next_state = st_idle;
    endcase
  end

  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  // handshake levels are registered from the next state
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      busy    <= 1'b0;
      cmd_end <= 1'b0;
    end else begin
      busy    <= (next_state != st_idle);
      cmd_end <= (next_state == st_wait);
    end
  end

  // operands and op code captured when the command is accepted
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      opa  <= '0;
      opb  <= '0;
      op_q <= op_add;
    end else if (state == st_idle && next_state == st_calc) begin
      opa  <= a;
      opb  <= b;
      op_q <= op;
    end
  end

  // pick the datapath by the captured op code
  always_comb begin
    case (op_q)
      op_add:  sel_result = addsub_result;
      op_sub:  sel_result = addsub_result;
      op_mul:  sel_result = mul_result;
      default: sel_result = '0;
    endcase
  end

  // result loaded at the end of the calc cycle
  // it then stays put until the next command
  always_ff @(posedge clk or posedge arst) begin
    if (arst) begin
      result <= '0;
    end else if (state == st_calc) begin
      result <= sel_result;
    end
  end

endmodule

//--- source/fpu_top.sv
// top level of the single-precision FPU
// the controller feeds registered operands to the add/sub and multiply datapaths
// and registers the selected result

`timescale 1ns/100ps

module fpu_top (
  input  logic                       clk,
  input  logic                       arst,
  input  logic [fpu_pkg::word_w-1:0] a,
  input  logic [fpu_pkg::word_w-1:0] b,
  input  logic [fpu_pkg::op_w-1:0]   op,
  input  logic                       start,
  output logic [fpu_pkg::word_w-1:0] result,
  output logic                       busy,
  output logic                       cmd_end
);
  import fpu_pkg::*;

  // registered operands and op code
  logic [word_w-1:0] opa;
  logic [word_w-1:0] opb;
  logic [op_w-1:0]   op_q;
  // datapath outputs back to the controller
  logic [word_w-1:0] addsub_result;
  logic [word_w-1:0] mul_result;

  fpu_control u_control (
    .clk           (clk),
    .arst          (arst),
    .a             (a),
    .b             (b),
    .op            (op),
    .start         (start),
    .addsub_result (addsub_result),
    .mul_result    (mul_result),
    .opa           (opa),
    .opb           (opb),
    .op_q          (op_q),
    .result        (result),
    .busy          (busy),
    .cmd_end       (cmd_end)
  );

  // add and subtract share one datapath
  fpu_addsub u_addsub (
    .opa           (opa),
    .opb           (opb),
    .op_q          (op_q),
    .addsub_result (addsub_result)
  );

  fpu_mul u_mul (
    .opa        (opa),
    .opb        (opb),
    .mul_result (mul_result)
  );

endmodule

//--- include/fpu_tb_vectors.svh
// command table for the FPU testbench, one command per row
// included inside the testbench module after the package import

`ifndef FPU_TB_VECTORS_SVH
`define FPU_TB_VECTORS_SVH

// row layout is {op, operand a, operand b, expected result}
localparam int row_w       = fpu_pkg::op_w + 3 * fpu_pkg::word_w;
localparam int num_vectors = 26;

logic [row_w-1:0] vectors [num_vectors];

task automatic load_vectors();
  // addition, equal and different exponents, carries, mixed signs
  vectors[0]  = {op_add, 32'h3F80_0000, 32'h3F80_0000, 32'h4000_0000};
  vectors[1]  = {op_add, 32'h3FC0_0000, 32'h3FC0_0000, 32'h4040_0000};
  vectors[2]  = {op_add, 32'h3F80_0000, 32'h3F00_0000, 32'h3FC0_0000};
  vectors[3]  = {op_add, 32'h4000_0000, 32'h3E80_0000, 32'h4010_0000};
  vectors[4]  = {op_add, 32'h4040_0000, 32'hBF80_0000, 32'h4000_0000};
  vectors[5]  = {op_add, 32'hBFC0_0000, 32'h3F00_0000, 32'hBF80_0000};
  vectors[6]  = {op_add, 32'hC000_0000, 32'hC000_0000, 32'hC080_0000};
  // subtraction, sign change, 23 bit left shift, exact cancellation
  vectors[7]  = {op_sub, 32'h3F80_0000, 32'h4040_0000, 32'hC000_0000};
  vectors[8]  = {op_sub, 32'h3F80_0001, 32'h3F80_0000, 32'h3400_0000};
  vectors[9]  = {op_sub, 32'h3FC0_0000, 32'h3FA0_0000, 32'h3E80_0000};
  vectors[10] = {op_sub, 32'h4049_0FDB, 32'h4049_0FDB, 32'h0000_0000};
  vectors[11] = {op_sub, 32'h40A0_0000, 32'hC040_0000, 32'h4100_0000};
  // unused op code 3
  vectors[12] = {2'd3,   32'h4040_0000, 32'h4000_0000, 32'h0000_0000};
  // multiply, exact, rounding carry, ties up and down to even
  vectors[13] = {op_mul, 32'h4000_0000, 32'h4040_0000, 32'h40C0_0000};
  vectors[14] = {op_mul, 32'h3FC0_0000, 32'h3FC0_0000, 32'h4010_0000};
  vectors[15] = {op_mul, 32'hC000_0000, 32'h3F00_0000, 32'hBF80_0000};
  vectors[16] = {op_mul, 32'h3FFF_FFFE, 32'h3F80_0001, 32'h4000_0000};
  vectors[17] = {op_mul, 32'h3F80_0001, 32'h3FC0_0000, 32'h3FC0_0002};
  vectors[18] = {op_mul, 32'h3F80_0003, 32'h3FC0_0000, 32'h3FC0_0004};
  // multiply special cases, NaN a wins over NaN b
  vectors[19] = {op_mul, 32'h7FC1_2345, 32'hFFA0_0000, 32'h7FC1_2345};
  vectors[20] = {op_mul, 32'h3F80_0000, 32'h7F81_2345, 32'h7F81_2345};
  vectors[21] = {op_mul, 32'h7F80_0000, 32'h0000_0000, 32'h7FC0_0000};
  vectors[22] = {op_mul, 32'h8000_0000, 32'hFF80_0000, 32'h7FC0_0000};
  vectors[23] = {op_mul, 32'hFF80_0000, 32'h4000_0000, 32'hFF80_0000};
  vectors[24] = {op_mul, 32'h7F80_0000, 32'hBF80_0000, 32'hFF80_0000};
  vectors[25] = {op_mul, 32'hBF80_0000, 32'h0000_0000, 32'h8000_0000};
endtask

`endif

//--- verification/fpu_tb.sv
// testbench for the FPU top level
// applies the command table through the start/busy/cmd_end handshake and checks each result

`timescale 1ns/100ps

module fpu_tb;
  import fpu_pkg::*;

  // longest wait for any handshake edge, in clock cycles
  localparam int timeout_cycles = 20;
  // inputs change this long after the rising edge
  localparam time drive_delay = 2ns;

  logic              clk = 1'b0;
  logic              arst;
  logic [word_w-1:0] a;
  logic [word_w-1:0] b;
  logic [op_w-1:0]   op;
  logic              start;
  logic [word_w-1:0] result;
  logic              busy;
  logic              cmd_end;

  `include "fpu_tb_vectors.svh"

  fpu_top uut (
    .clk     (clk),
    .arst    (arst),
    .a       (a),
    .b       (b),
    .op      (op),
    .start   (start),
    .result  (result),
    .busy    (busy),
    .cmd_end (cmd_end)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // report the failure and stop the run
  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_word(input string name, input logic [word_w-1:0] expected,
                            input logic [word_w-1:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("Error: %s expected %h actual %h", name, expected, actual));
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      abort_run($sformatf("Error: %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // step to the next drive point
  task automatic next_cycle();
    @(posedge clk);
    #drive_delay;
  endtask

  // one table row as a full command, start held for extra cycles after cmd_end
  task automatic run_command(input int idx);
    logic [op_w-1:0]   row_op;
    logic [word_w-1:0] row_a;
    logic [word_w-1:0] row_b;
    logic [word_w-1:0] row_exp;
    int                cycles;
    int                extra;
    {row_op, row_a, row_b, row_exp} = vectors[idx];
    extra = $urandom % 6;
    a     = row_a;
    b     = row_b;
    op    = row_op;
    start = 1'b1;

    // busy follows the edge that samples start
    cycles = 0;
    while (!busy && cycles < timeout_cycles) begin
      next_cycle();
      cycles++;
    end
    if (!busy) begin
      abort_run($sformatf("timeout waiting for busy to rise on row %0d", idx));
    end
    if (cycles != 1) begin
      abort_run($sformatf("busy rose %0d cycles after start on row %0d, not 1",
                          cycles, idx));
    end
    check_flag("cmd_end", 1'b0, cmd_end);
    // operands are already captured, scramble the inputs
    a  = ~row_a;
    b  = ~row_b;
    op = ~row_op;

    // cmd_end counted from the sampling edge
    cycles = 0;
    while (!cmd_end && cycles < timeout_cycles) begin
      next_cycle();
      cycles++;
    end
    if (!cmd_end) begin
      abort_run($sformatf("timeout waiting for cmd_end to rise on row %0d", idx));
    end
    if (cycles != 2) begin
      abort_run($sformatf("cmd_end rose %0d cycles after start on row %0d, not 2",
                          cycles, idx));
    end
    check_flag("busy", 1'b1, busy);
    check_word("result", row_exp, result);

    // holding start keeps everything still
    for (int k = 0; k < extra; k++) begin
      next_cycle();
      check_flag("busy", 1'b1, busy);
      check_flag("cmd_end", 1'b1, cmd_end);
      check_word("result", row_exp, result);
    end

    start = 1'b0;
    cycles = 0;
    while ((busy || cmd_end) && cycles < timeout_cycles) begin
      next_cycle();
      cycles++;
    end
    if (busy || cmd_end) begin
      abort_run($sformatf("timeout waiting for busy and cmd_end to fall on row %0d", idx));
    end
    if (cycles != 1) begin
      abort_run($sformatf("handshake fell %0d cycles after start dropped on row %0d, not 1",
                          cycles, idx));
    end
    // registered result survives the return to idle
    check_word("result", row_exp, result);
  endtask

  initial begin
    // one seed for the whole run
    void'($urandom(7959));
    arst  = 1'b1;
    a     = '0;
    b     = '0;
    op    = op_add;
    start = 1'b0;
    load_vectors();

    // reset for 10 cycles
    repeat (10) @(posedge clk);
    #drive_delay;
    arst = 1'b0;
    check_flag("busy", 1'b0, busy);
    check_flag("cmd_end", 1'b0, cmd_end);
    check_word("result", '0, result);

    next_cycle();
    for (int i = 0; i < num_vectors; i++) begin
      run_command(i);
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- project.f
source/fpu_pkg.sv
source/fpu_addsub.sv
source/fpu_mul.sv
source/fpu_control.sv
source/fpu_top.sv
+incdir+include
verification/fpu_tb.sv
